// ==== tb.f ====
+incdir+verilog
verilog/his_pkg.sv
verilog/his_event_decode.sv
verilog/his_accumulate.sv
verilog/his_axil_readout.sv
verilog/his_top.sv
tb/tb_clkgen.sv
tb/tb_his.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the histogram testbench with verilator and run it
set -u

cd "$(dirname "$0")" || exit 1

obj_dir=obj_dir
log=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_his -f tb.f -Mdir "$obj_dir" -o tb_his_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$obj_dir/tb_his_sim" > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

# verdict comes from the log
if grep -q "=== FAIL ===" "$log"; then
    exit 1
fi
exit 0

// ==== tb/tb_his.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "his_cfg.svh"

module tb_his;

    localparam int WIN_NUM = `HIS_ACQ_NUM * `HIS_PIXEL_NUM * `HIS_DATA_NUM;
    localparam int WORDS   = 1 << `HIS_ADDR_W;
    localparam int AW      = `HIS_AXI_AW;
    localparam int CODE_W  = `HIS_CODE_W;
    localparam int LIMIT   = 400;

    localparam logic [1:0]      OKAY         = 2'b00;
    localparam logic [1:0]      SLVERR       = 2'b10;
    localparam logic [AW-1:0]   STATUS_ADDR  = AW'('h100);
    localparam logic [AW-1:0]   RELEASE_ADDR = AW'('h104);
    localparam logic [CODE_W-1:0] CODE_MOD   = CODE_W'(`HIS_BIN_NUM + 1);

    logic                   clk;
    logic                   res;
    logic                   hit_valid;
    logic [CODE_W-1:0]      hit_code;
    logic                   hit_ready;
    logic [AW-1:0]          awaddr;
    logic                   awvalid;
    logic                   awready;
    logic [`HIS_AXI_DW-1:0] wdata;
    logic [3:0]             wstrb;
    logic                   wvalid;
    logic                   wready;
    logic [1:0]             bresp;
    logic                   bvalid;
    logic                   bready;
    logic [AW-1:0]          araddr;
    logic                   arvalid;
    logic                   arready;
    logic [`HIS_AXI_DW-1:0] rdata;
    logic [1:0]             rresp;
    logic                   rvalid;
    logic                   rready;

    // code list of the histogram in flight and its expected words
    logic [31:0]       lfsr_state;
    logic [CODE_W-1:0] codes [WIN_NUM];
    logic [31:0]       exp_hist [WORDS];

    // pending comparisons, drained by the compare process
    logic [31:0] exp_q [$];
    logic [31:0] act_q [$];
    string       name_q [$];

    int errs;
    int errs_mark;
    int n_checks;
    int n_pass;
    int n_fail;

    tb_clkgen i_clkgen (
        .clk (clk),
        .res (res)
    );

    his_top i_dut (
        .clk       (clk),
        .res       (res),
        .hit_valid (hit_valid),
        .hit_code  (hit_code),
        .hit_ready (hit_ready),
        .awaddr    (awaddr),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .wvalid    (wvalid),
        .wready    (wready),
        .bresp     (bresp),
        .bvalid    (bvalid),
        .bready    (bready),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata     (rdata),
        .rresp     (rresp),
        .rvalid    (rvalid),
        .rready    (rready)
    );

    // x^32 + x^22 + x^2 + x + 1, shift left, feedback into bit 0
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // five fresh bits per code, folded onto 0..16
    function automatic logic [CODE_W-1:0] rand_code();
        logic [CODE_W-1:0] v;
        v = '0;
        for (int b = 0; b < CODE_W; b++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[CODE_W-2:0], lfsr_state[0]};
        end
        return v % CODE_MOD;
    endfunction

    // expected bank from the code list, scan order window/pixel/acquisition
    function automatic void build_ref(input logic [CODE_W-1:0] cl [WIN_NUM]);
        int pix;
        for (int w = 0; w < WORDS; w++) begin
            exp_hist[w] = 0;
        end
        for (int i = 0; i < WIN_NUM; i++) begin
            pix = (i / `HIS_DATA_NUM) % `HIS_PIXEL_NUM;
            // code 0 is an empty window
            if (cl[i] != 0) begin
                exp_hist[pix * `HIS_BIN_NUM + int'(cl[i]) - 1] += 1;
            end
        end
    endfunction

    task automatic stop_on_timeout(input string what);
        $display("timeout: %s", what);
        $display("=== FAIL ===");
        $finish;
    endtask

    task automatic expect_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        exp_q.push_back(exp);
        act_q.push_back(act);
        name_q.push_back(name);
    endtask

    task automatic wait_reset();
        int n;
        n = 0;
        while (res !== 1'b1) begin
            @(posedge clk);
            n++;
            if (n >= LIMIT) stop_on_timeout("reset never released");
        end
        @(posedge clk);
    endtask

    // ready only moves on rising edges, so the falling edge sees the value the DUT samples
    task automatic wait_accept();
        int n;
        n = 0;
        @(negedge clk);
        while (!hit_ready) begin
            n++;
            if (n >= LIMIT) stop_on_timeout("hit_ready stayed low, window never accepted");
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    task automatic send_windows(input int from, input int upto);
        for (int i = from; i < upto; i++) begin
            hit_valid <= 1'b1;
            hit_code  <= codes[i];
            wait_accept();
        end
        hit_valid <= 1'b0;
    endtask

    task automatic axi_read(input logic [AW-1:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        int n;
        araddr  <= addr;
        arvalid <= 1'b1;
        n = 0;
        @(negedge clk);
        while (!arready) begin
            n++;
            if (n >= LIMIT) stop_on_timeout("arready never rose");
            @(negedge clk);
        end
        @(posedge clk);
        arvalid <= 1'b0;
        rready  <= 1'b1;
        n = 0;
        @(negedge clk);
        while (!rvalid) begin
            n++;
            if (n >= LIMIT) stop_on_timeout("no read response");
            @(negedge clk);
        end
        data = rdata;
        resp = rresp;
        @(posedge clk);
        rready <= 1'b0;
    endtask

    task automatic axi_write(input logic [AW-1:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        int n;
        awaddr  <= addr;
        awvalid <= 1'b1;
        wdata   <= data;
        wstrb   <= 4'hf;
        wvalid  <= 1'b1;
        n = 0;
        @(negedge clk);
        while (!awready) begin
            n++;
            if (n >= LIMIT) stop_on_timeout("awready never rose");
            @(negedge clk);
        end
        // address and data channels accept together
        expect_val("wready with awready", 32'h1, 32'(wready));
        @(posedge clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        bready  <= 1'b1;
        n = 0;
        @(negedge clk);
        while (!bvalid) begin
            n++;
            if (n >= LIMIT) stop_on_timeout("no write response");
            @(negedge clk);
        end
        resp = bresp;
        @(posedge clk);
        bready <= 1'b0;
    endtask

    // poll status until the masked bits match
    task automatic wait_status(input logic [2:0] want, input logic [2:0] mask);
        logic [31:0] d;
        logic [1:0]  r;
        int          n;
        n = 0;
        axi_read(STATUS_ADDR, d, r);
        while ((d[2:0] & mask) != want) begin
            n++;
            if (n >= LIMIT) stop_on_timeout($sformatf("status never reached %b", want));
            axi_read(STATUS_ADDR, d, r);
        end
    endtask

    task automatic check_status(input string name, input logic [2:0] want);
        logic [31:0] d;
        logic [1:0]  r;
        axi_read(STATUS_ADDR, d, r);
        expect_val(name, 32'(want), d);
        expect_val({name, " resp"}, 32'(OKAY), 32'(r));
    endtask

    // write 1 to the release register
    task automatic release_bank(input string name);
        logic [1:0] r;
        axi_write(RELEASE_ADDR, 32'h1, r);
        expect_val({name, " release resp"}, 32'(OKAY), 32'(r));
    endtask

    task automatic compare_bank(input string name);
        logic [31:0] d;
        logic [1:0]  r;
        for (int w = 0; w < WORDS; w++) begin
            axi_read(AW'(w * 4), d, r);
            expect_val($sformatf("%s word %0d", name, w), exp_hist[w], d);
            expect_val($sformatf("%s resp %0d", name, w), 32'(OKAY), 32'(r));
        end
    endtask

    task automatic fill_random();
        for (int i = 0; i < WIN_NUM; i++) begin
            codes[i] = rand_code();
        end
    endtask

    task automatic finish_test(input string name);
        int n;
        n = 0;
        while (act_q.size() != 0) begin
            @(posedge clk);
            n++;
            if (n >= LIMIT) stop_on_timeout("compare queue never drained");
        end
        if (errs == errs_mark) begin
            n_pass++;
            $display("test %s: ok", name);
        end else begin
            n_fail++;
            $display("test %s: %0d wrong values", name, errs - errs_mark);
        end
        errs_mark = errs;
    endtask

    // compare process, one batch per falling edge
    initial begin : compare
        logic [31:0] e;
        logic [31:0] a;
        string       nm;
        forever begin
            @(negedge clk);
            while (act_q.size() != 0) begin
                e  = exp_q.pop_front();
                a  = act_q.pop_front();
                nm = name_q.pop_front();
                n_checks++;
                assert (a === e) else begin
                    $display("FAIL %s: expected 0x%0h, actual 0x%0h", nm, e, a);
                    errs++;
                end
            end
        end
    end

    initial begin : main
        logic [31:0] d;
        logic [1:0]  r;
        hit_valid  = 1'b0;
        hit_code   = '0;
        awaddr     = '0;
        awvalid    = 1'b0;
        wdata      = '0;
        wstrb      = '0;
        wvalid     = 1'b0;
        bready     = 1'b0;
        araddr     = '0;
        arvalid    = 1'b0;
        rready     = 1'b0;
        lfsr_state = 32'h03624589;
        errs       = 0;
        errs_mark  = 0;
        n_checks   = 0;
        n_pass     = 0;
        n_fail     = 0;
        wait_reset();

        // idle after reset, no done bank yet
        check_status("reset status", 3'b000);
        @(negedge clk);
        expect_val("reset hit_ready", 32'h1, 32'(hit_ready));
        @(posedge clk);
        axi_read(AW'('h000), d, r);
        expect_val("bin read without done bank", 32'(SLVERR), 32'(r));
        finish_test("reset state");

        // random codes into bank 0
        fill_random();
        build_ref(codes);
        send_windows(0, WIN_NUM);
        wait_status(3'b001, 3'b111);
        check_status("random hist status", 3'b001);
        compare_bank("random hist");
        release_bank("random hist");
        wait_status(3'b000, 3'b101);
        finish_test("random histogram");

        // one code all the way through, same word back to back
        for (int i = 0; i < WIN_NUM; i++) begin
            codes[i] = CODE_W'(9);
        end
        build_ref(codes);
        send_windows(0, WIN_NUM);
        wait_status(3'b011, 3'b111);
        check_status("repeat hist status", 3'b011);
        compare_bank("repeat hist");
        release_bank("repeat hist");
        wait_status(3'b000, 3'b101);
        finish_test("repeated code");

        // bank 0 fills and stays unreleased
        fill_random();
        build_ref(codes);
        send_windows(0, WIN_NUM);
        wait_status(3'b001, 3'b111);
        compare_bank("held hist");
        // next histogram, all but its last window
        fill_random();
        build_ref(codes);
        send_windows(0, WIN_NUM - 1);
        hit_valid <= 1'b1;
        hit_code  <= codes[WIN_NUM - 1];
        repeat (20) begin
            @(negedge clk);
            expect_val("last window stalled", 32'h0, 32'(hit_ready));
        end
        @(posedge clk);
        // last window goes in once the sweep of bank 0 ends
        fork
            begin
                wait_accept();
                hit_valid <= 1'b0;
            end
            begin
                release_bank("held hist");
                wait_status(3'b011, 3'b111);
            end
        join
        check_status("stalled hist status", 3'b011);
        compare_bank("stalled hist");
        finish_test("stall on busy bank");

        // bank 0 again, old counts must be gone
        release_bank("stalled hist");
        wait_status(3'b000, 3'b101);
        fill_random();
        build_ref(codes);
        send_windows(0, WIN_NUM);
        wait_status(3'b001, 3'b111);
        compare_bank("refill hist");
        finish_test("clear before refill");

        // error responses, then a release with nothing done
        axi_read(AW'('h200), d, r);
        expect_val("unmapped read resp", 32'(SLVERR), 32'(r));
        axi_write(AW'('h000), 32'h1, r);
        expect_val("bin write resp", 32'(SLVERR), 32'(r));
        axi_write(STATUS_ADDR, 32'h1, r);
        expect_val("status write resp", 32'(SLVERR), 32'(r));
        check_status("status after bad writes", 3'b001);
        release_bank("refill hist");
        wait_status(3'b000, 3'b101);
        axi_write(RELEASE_ADDR, 32'h1, r);
        expect_val("idle release resp", 32'(OKAY), 32'(r));
        check_status("status after idle release", 3'b000);
        axi_read(RELEASE_ADDR, d, r);
        expect_val("release read data", 32'h0, d);
        expect_val("release read resp", 32'(OKAY), 32'(r));
        finish_test("error responses");

        $display("tests passed %0d, failed %0d; checks %0d, wrong %0d",
                 n_pass, n_fail, n_checks, errs);
        if (n_fail == 0 && errs == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/tb_clkgen.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clkgen (
    output logic clk,
    output logic res
);

    // half of the 100 ns period
    localparam int HALF_NS = 50;

    // free-running clock, first rising edge at 50 ns
    initial begin
        clk = 1'b0;
        forever #(HALF_NS) clk = ~clk;
    end

    // reset held low over the first three rising edges
    initial begin
        res = 1'b0;
        repeat (3) @(posedge clk);
        res <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== verilog/his_top.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "his_cfg.svh"

module his_top (
    input  wire logic                   clk,
    input  wire logic                   res,
    // tdc event input
    input  wire logic                   hit_valid,
    input  wire logic [`HIS_CODE_W-1:0] hit_code,
    output logic                        hit_ready,
    // axi4-lite slave
    input  wire logic [`HIS_AXI_AW-1:0] awaddr,
    input  wire logic                   awvalid,
    output logic                        awready,
    input  wire logic [`HIS_AXI_DW-1:0] wdata,
    input  wire logic [3:0]             wstrb,
    input  wire logic                   wvalid,
    output logic                        wready,
    output logic [1:0]                  bresp,
    output logic                        bvalid,
    input  wire logic                   bready,
    input  wire logic [`HIS_AXI_AW-1:0] araddr,
    input  wire logic                   arvalid,
    output logic                        arready,
    output logic [`HIS_AXI_DW-1:0]      rdata,
    output logic [1:0]                  rresp,
    output logic                        rvalid,
    input  wire logic                   rready
);

    his_pkg::his_upd_t      upd;
    logic                   upd_valid;
    logic                   bank_free;
    his_pkg::his_bank_t     status;
    logic [`HIS_ADDR_W-1:0] rd_addr;
    logic [`HIS_CNT_W-1:0]  rd_data;
    logic                   release_pulse;

    // window counting and bin address
    his_event_decode u_decode (
        .clk       (clk),
        .res       (res),
        .hit_valid (hit_valid),
        .hit_code  (hit_code),
        .hit_ready (hit_ready),
        .bank_free (bank_free),
        .upd_valid (upd_valid),
        .upd       (upd)
    );

    // two banks, increment pipeline, clear sweep
    his_accumulate u_accum (
        .clk           (clk),
        .res           (res),
        .upd_valid     (upd_valid),
        .upd           (upd),
        .bank_free     (bank_free),
        .release_pulse (release_pulse),
        .status        (status),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data)
    );

    // software view of the done bank
    his_axil_readout u_readout (
        .clk           (clk),
        .res           (res),
        .awaddr        (awaddr),
        .awvalid       (awvalid),
        .awready       (awready),
        .wdata         (wdata),
        .wstrb         (wstrb),
        .wvalid        (wvalid),
        .wready        (wready),
        .bresp         (bresp),
        .bvalid        (bvalid),
        .bready        (bready),
        .araddr        (araddr),
        .arvalid       (arvalid),
        .arready       (arready),
        .rdata         (rdata),
        .rresp         (rresp),
        .rvalid        (rvalid),
        .rready        (rready),
        .status        (status),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data),
        .release_pulse (release_pulse)
    );

endmodule

`default_nettype wire

// ==== verilog/his_axil_readout.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "his_cfg.svh"

module his_axil_readout (
    input  wire logic                   clk,
    input  wire logic                   res,
    input  wire logic [`HIS_AXI_AW-1:0] awaddr,
    input  wire logic                   awvalid,
    output logic                        awready,
    input  wire logic [`HIS_AXI_DW-1:0] wdata,
    // strobes ignored, full-word writes only
    input  wire logic [3:0]             wstrb,
    input  wire logic                   wvalid,
    output logic                        wready,
    output logic [1:0]                  bresp,
    output logic                        bvalid,
    input  wire logic                   bready,
    input  wire logic [`HIS_AXI_AW-1:0] araddr,
    input  wire logic                   arvalid,
    output logic                        arready,
    output logic [`HIS_AXI_DW-1:0]      rdata,
    output logic [1:0]                  rresp,
    output logic                        rvalid,
    input  wire logic                   rready,
    input  wire his_pkg::his_bank_t     status,
    output logic [`HIS_ADDR_W-1:0]      rd_addr,
    input  wire logic [`HIS_CNT_W-1:0]  rd_data,
    output logic                        release_pulse
);

    localparam int          ADDR_W = `HIS_ADDR_W;
    localparam int          DW     = `HIS_AXI_DW;
    localparam logic [1:0]  OKAY   = 2'b00;
    localparam logic [1:0]  SLVERR = 2'b10;

    his_pkg::his_reg_e rd_kind;
    his_pkg::his_reg_e wr_kind;
    logic              ar_hs;
    logic              aw_hs;

    // 0x000..0x0fc bins, 0x100 status, 0x104 release
    function automatic his_pkg::his_reg_e reg_kind(input logic [`HIS_AXI_AW-1:0] a);
        if (a < 'h100) begin
            return his_pkg::REG_BIN;
        end else if (a == 'h100) begin
            return his_pkg::REG_STATUS;
        end else if (a == 'h104) begin
            return his_pkg::REG_RELEASE;
        end
        return his_pkg::REG_NONE;
    endfunction

    assign rd_kind = reg_kind(araddr);
    assign wr_kind = reg_kind(awaddr);

    // byte address to bank word
    assign rd_addr = araddr[ADDR_W+1:2];

    // read address taken while no response waits
    assign arready = !rvalid;
    assign ar_hs   = arvalid && arready;

    // address and data taken together, one cycle
    assign aw_hs   = awvalid && wvalid && !bvalid;
    assign awready = aw_hs;
    assign wready  = aw_hs;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            rvalid        <= 1'b0;
            bvalid        <= 1'b0;
            release_pulse <= 1'b0;
        end else begin
            if (ar_hs) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
            if (aw_hs) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            // bit 0 releases, only with a done bank
            release_pulse <= aw_hs && (wr_kind == his_pkg::REG_RELEASE) && wdata[0]
                          && status.done_valid;
        end
    end

    // read response captured at the handshake
    always_ff @(posedge clk) begin
        if (ar_hs) begin
            case (rd_kind)
                his_pkg::REG_BIN: begin
                    rdata <= DW'(rd_data);
                    // no done bank, no valid bins
                    rresp <= status.done_valid ? OKAY : SLVERR;
                end
                his_pkg::REG_STATUS: begin
                    rdata <= DW'({status.clearing, status.done_bank, status.done_valid});
                    rresp <= OKAY;
                end
                his_pkg::REG_RELEASE: begin
                    rdata <= '0;
                    rresp <= OKAY;
                end
                default: begin
                    rdata <= '0;
                    rresp <= SLVERR;
                end
            endcase
        end
    end

    // only release accepts a write
    always_ff @(posedge clk) begin
        if (aw_hs) begin
            bresp <= (wr_kind == his_pkg::REG_RELEASE) ? OKAY : SLVERR;
        end
    end

    // response held steady until the master takes it
    a_r_stable: assert property (@(posedge clk) disable iff (!res)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

endmodule

`default_nettype wire

// ==== verilog/his_accumulate.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "his_cfg.svh"

module his_accumulate (
    input  wire logic                   clk,
    input  wire logic                   res,
    input  wire logic                   upd_valid,
    input  wire his_pkg::his_upd_t      upd,
    output logic                        bank_free,
    input  wire logic                   release_pulse,
    output his_pkg::his_bank_t          status,
    input  wire logic [`HIS_ADDR_W-1:0] rd_addr,
    output logic [`HIS_CNT_W-1:0]       rd_data
);

    localparam int ADDR_W = `HIS_ADDR_W;
    localparam int CNT_W  = `HIS_CNT_W;
    localparam int WORDS  = 1 << ADDR_W;

    // both banks, bank select is the top index bit
    logic [CNT_W-1:0]  mem [2*WORDS];

    logic              act_q;
    logic              act_nxt;
    logic              done_q;
    logic              done_bank_q;
    his_pkg::his_clr_e clr_q;
    logic [ADDR_W-1:0] clr_addr;

    logic              s1_valid;
    logic              s1_hit;
    logic              s1_last;
    logic [ADDR_W:0]   s1_idx;
    logic [CNT_W-1:0]  s1_cnt;
    logic [ADDR_W:0]   rd_idx;
    logic [CNT_W-1:0]  wr_val;
    logic              wr_en;
    logic              swap;

    // bram power-up contents
    initial begin
        for (int i = 0; i < 2*WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // last window leaves stage 1, bank flips on this edge
    assign swap    = s1_valid && s1_last;
    assign act_nxt = act_q ^ swap;

    // stage 2 write, count plus one
    assign wr_en  = s1_valid && s1_hit;
    assign wr_val = s1_cnt + 1'b1;

    // first window of the next histogram already reads the new bank
    assign rd_idx = {act_nxt, upd.addr};

    // stage 1, read with forwarding
    always_ff @(posedge clk) begin
        s1_hit  <= upd.hit;
        s1_last <= upd.last;
        s1_idx  <= rd_idx;
        // write landing on the same edge wins
        if (wr_en && (s1_idx == rd_idx)) begin
            s1_cnt <= wr_val;
        end else begin
            s1_cnt <= mem[rd_idx];
        end
    end

    // increment port and clear port hit different banks
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[s1_idx] <= wr_val;
        end
        if (clr_q == his_pkg::CLR_RUN) begin
            mem[{done_bank_q, clr_addr}] <= '0;
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s1_valid    <= 1'b0;
            act_q       <= 1'b0;
            done_q      <= 1'b0;
            done_bank_q <= 1'b0;
            clr_q       <= his_pkg::CLR_IDLE;
            clr_addr    <= '0;
        end else begin
            s1_valid <= upd_valid;
            act_q    <= act_nxt;
            // finished bank handed to software
            if (swap) begin
                done_q      <= 1'b1;
                done_bank_q <= act_q;
            end
            case (clr_q)
                his_pkg::CLR_IDLE: begin
                    if (release_pulse && done_q) begin
                        clr_q    <= his_pkg::CLR_RUN;
                        clr_addr <= '0;
                        done_q   <= 1'b0;
                    end
                end
                his_pkg::CLR_RUN: begin
                    // one word per cycle
                    clr_addr <= clr_addr + 1'b1;
                    if (&clr_addr) begin
                        clr_q <= his_pkg::CLR_IDLE;
                    end
                end
                default: clr_q <= his_pkg::CLR_IDLE;
            endcase
        end
    end

    // other bank neither waiting for software nor being wiped
    assign bank_free = !done_q && (clr_q == his_pkg::CLR_IDLE);

    assign status.done_valid = done_q;
    assign status.done_bank  = done_bank_q;
    assign status.clearing   = (clr_q == his_pkg::CLR_RUN);

    // readout port on the done bank
    assign rd_data = mem[{done_bank_q, rd_addr}];

    // bank taken over at a swap is not owned by software or the sweep
    a_upd_bank: assert property (@(posedge clk) disable iff (!res)
        swap |-> !done_q && (clr_q == his_pkg::CLR_IDLE));

    // readout only releases a finished bank
    a_release: assert property (@(posedge clk) disable iff (!res)
        release_pulse |-> done_q);

endmodule

`default_nettype wire

// ==== verilog/his_event_decode.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "his_cfg.svh"

module his_event_decode (
    input  wire logic                   clk,
    input  wire logic                   res,
    input  wire logic                   hit_valid,
    input  wire logic [`HIS_CODE_W-1:0] hit_code,
    output logic                        hit_ready,
    input  wire logic                   bank_free,
    output logic                        upd_valid,
    output his_pkg::his_upd_t           upd
);

    localparam int ADDR_W = `HIS_ADDR_W;
    localparam int WIN_W  = $clog2(`HIS_DATA_NUM);
    localparam int PIX_W  = $clog2(`HIS_PIXEL_NUM);
    localparam int ACQ_W  = $clog2(`HIS_ACQ_NUM);

    logic [WIN_W-1:0]    win_q;
    logic [WIN_W-1:0]    win_d;
    logic [PIX_W-1:0]    pix_q;
    logic [PIX_W-1:0]    pix_d;
    logic [ACQ_W-1:0]    acq_q;
    logic [ACQ_W-1:0]    acq_d;
    his_pkg::his_frame_e frame_q;
    his_pkg::his_frame_e frame_d;
    logic                acc;
    logic                last_win;
    logic                last_nxt;

    // window taken on valid and ready
    assign acc       = hit_valid && hit_ready;
    assign hit_ready = (frame_q == his_pkg::FRAME_RUN);

    // position of the final window of a histogram
    assign last_win = (win_q == `HIS_DATA_NUM - 1) && (pix_q == `HIS_PIXEL_NUM - 1)
                   && (acq_q == `HIS_ACQ_NUM - 1);
    assign last_nxt = (win_d == `HIS_DATA_NUM - 1) && (pix_d == `HIS_PIXEL_NUM - 1)
                   && (acq_d == `HIS_ACQ_NUM - 1);

    // window, then pixel, then acquisition
    always_comb begin
        win_d = win_q;
        pix_d = pix_q;
        acq_d = acq_q;
        if (acc) begin
            if (win_q == `HIS_DATA_NUM - 1) begin
                win_d = '0;
                if (pix_q == `HIS_PIXEL_NUM - 1) begin
                    pix_d = '0;
                    if (acq_q == `HIS_ACQ_NUM - 1) begin
                        acq_d = '0;
                    end else begin
                        acq_d = acq_q + 1'b1;
                    end
                end else begin
                    pix_d = pix_q + 1'b1;
                end
            end else begin
                win_d = win_q + 1'b1;
            end
        end
    end

    // hold the last window back while the next bank is busy
    assign frame_d = (last_nxt && !bank_free) ? his_pkg::FRAME_STALL : his_pkg::FRAME_RUN;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            win_q     <= '0;
            pix_q     <= '0;
            acq_q     <= '0;
            frame_q   <= his_pkg::FRAME_RUN;
            upd_valid <= 1'b0;
        end else begin
            win_q     <= win_d;
            pix_q     <= pix_d;
            acq_q     <= acq_d;
            frame_q   <= frame_d;
            upd_valid <= acc;
        end
    end

    // bank word is pixel * bins + code - 1
    // code 0 gives a dummy address, hit stays low
    always_ff @(posedge clk) begin
        if (acc) begin
            upd.hit  <= (hit_code != '0);
            upd.addr <= ADDR_W'(pix_q * `HIS_BIN_NUM + hit_code - 1);
            upd.last <= last_win;
        end
    end

    // front end never hands over a code beyond the last bin
    a_code_range: assert property (@(posedge clk) disable iff (!res)
        acc |-> hit_code <= `HIS_BIN_NUM);

endmodule

`default_nettype wire

// ==== verilog/his_pkg.sv ====
`default_nettype none
`include "his_cfg.svh"

package his_pkg;

    // one accumulation request from decode
    typedef struct packed {
        logic                   hit;
        logic [`HIS_ADDR_W-1:0] addr;
        // last window of last acquisition
        logic                   last;
    } his_upd_t;

    // bank status towards the readout
    typedef struct packed {
        logic done_valid;
        logic done_bank;
        logic clearing;
    } his_bank_t;

    // decode frame state
    typedef enum logic {
        FRAME_RUN,
        FRAME_STALL
    } his_frame_e;

    // clear sweep state
    typedef enum logic {
        CLR_IDLE,
        CLR_RUN
    } his_clr_e;

    // register kind behind an axi address
    typedef enum logic [1:0] {
        REG_BIN,
        REG_STATUS,
        REG_RELEASE,
        REG_NONE
    } his_reg_e;

endpackage

`default_nettype wire

// ==== verilog/his_cfg.svh ====
`ifndef HIS_CFG_SVH
`define HIS_CFG_SVH

// timing bins per pixel
`define HIS_BIN_NUM 16
// bin code width, holds 0 to HIS_BIN_NUM
`define HIS_CODE_W 5

// pixels in one acquisition scan
`define HIS_PIXEL_NUM 4
// detection windows per pixel
`define HIS_DATA_NUM 4
// acquisitions summed into one histogram
`define HIS_ACQ_NUM 3

// bin counter width, sized for HIS_ACQ_NUM * HIS_DATA_NUM counts
`define HIS_CNT_W 8
// word address inside one bank
`define HIS_ADDR_W 6

// axi4-lite bus widths
`define HIS_AXI_AW 12
`define HIS_AXI_DW 32

`endif
